//--- Makefile
TOP = stepper_spi_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f stepper_spi_top.f -o Vsim
	./obj_dir/Vsim | tee /dev/stderr | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

//--- hdl/dda_step_timer.sv
`timescale 1ns/1ps
`include "stepper_defines.svh"

module dda_step_timer
  import stepper_pkg::*;
(
  input  logic                         CLK,
  input  logic                         resetn,
  input  logic [7:0]                   clock_divisor,
  input  move_params_t                 move_buf [`MOVE_BUFFER_SIZE],
  input  logic [`MOVE_BUFFER_SIZE-1:0] stepready,
  output logic [`MOVE_BUFFER_SIZE-1:0] stepfinished,
  output logic                         step,
  output logic                         dir
);

  localparam int IDX_W = `MOVE_INDEX_BITS;
  localparam logic [IDX_W-1:0] LAST_IND = IDX_W'(`MOVE_BUFFER_SIZE - 1);

  dda_state_e         state;
  logic [7:0]         div_cnt;
  logic               tick;
  logic [IDX_W-1:0]   read_ind;
  logic               pending;
  // Active move
  logic [63:0]        duration;
  logic [63:0]        tick_cnt;
  logic signed [63:0] accum;
  logic signed [63:0] increment;
  logic signed [63:0] incinc;
  logic signed [63:0] accum_next;

  assign pending    = stepready[read_ind] != stepfinished[read_ind];
  assign accum_next = accum + increment;

  // Prescaler makes one tick every clock_divisor cycles
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end else if (div_cnt + 8'd1 >= clock_divisor) begin
      div_cnt <= '0;
      tick    <= 1'b1;
    end else begin
      div_cnt <= div_cnt + 8'd1;
      tick    <= 1'b0;
    end
  end

  // Slot sequencing and pins
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state        <= DDA_IDLE;
      read_ind     <= '0;
      stepfinished <= '0;
      step         <= 1'b0;
      dir          <= 1'b0;
    end else begin
      step <= 1'b0;
      if (tick) begin
        case (state)
          DDA_IDLE: begin
            if (pending) begin
              dir   <= move_buf[read_ind].dir;
              state <= DDA_RUN;
            end
          end
          DDA_RUN: begin
            // One step when the integer part moves
            step <= accum_next[63:32] != accum[63:32];
            if (tick_cnt + 64'd1 >= duration) begin
              stepfinished[read_ind] <= ~stepfinished[read_ind];
              read_ind               <= (read_ind == LAST_IND) ? '0 : read_ind + 1'b1;
              state                  <= DDA_IDLE;
            end
          end
          default: state <= DDA_IDLE;
        endcase
      end
    end
  end

  // DDA datapath
  always_ff @(posedge CLK) begin
    if (tick) begin
      if (state == DDA_IDLE) begin
        if (pending) begin
          accum     <= '0;
          tick_cnt  <= '0;
          duration  <= move_buf[read_ind].duration;
          increment <= move_buf[read_ind].increment;
          incinc    <= move_buf[read_ind].incinc;
        end
      end else begin
        accum     <= accum_next;
        increment <= increment + incinc;
        tick_cnt  <= tick_cnt + 64'd1;
      end
    end
  end

  // Step pulses come only from a running move on a slot still pending
  a_step_in_run: assert property (@(posedge CLK) disable iff (!resetn)
    step |-> $past(state == DDA_RUN && pending));

endmodule

//--- hdl/move_command_fsm.sv
`timescale 1ns/1ps
`include "stepper_defines.svh"

module move_command_fsm
  import stepper_pkg::*;
(
  input  logic                         CLK,
  input  logic                         resetn,
  input  logic                         word_rx,
  input  logic [63:0]                  word_rx_data,
  input  logic [63:0]                  encoder_count,
  input  logic [`MOVE_BUFFER_SIZE-1:0] stepfinished,
  output logic [63:0]                  word_tx_data,
  output motor_config_t                motor_cfg,
  output logic [7:0]                   clock_divisor,
  output move_params_t                 move_buf [`MOVE_BUFFER_SIZE],
  output logic [`MOVE_BUFFER_SIZE-1:0] stepready,
  output logic                         buffer_dtr
);

  localparam int IDX_W = `MOVE_INDEX_BITS;
  localparam logic [IDX_W-1:0] LAST_IND = IDX_W'(`MOVE_BUFFER_SIZE - 1);

  msg_state_e       state;
  cmd_e             opcode;
  logic [IDX_W-1:0] wr_ind;
  // Encoder snapshot taken at the move header
  logic [63:0]      encoder_store;
  // Any word that writes into the move buffer
  logic             move_word;

  assign opcode = cmd_e'(word_rx_data[63:56]);

  // Slot is free once the timer has caught up with it
  assign buffer_dtr = (stepready[wr_ind] == stepfinished[wr_ind]);

  assign move_word = word_rx &&
    ((state == MSG_HEADER && opcode == CMD_COORDINATED_STEP) ||
     state == MSG_DURATION || state == MSG_INCREMENT || state == MSG_INCINC);

  // Message sequencing, configuration and reply
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state                     <= MSG_HEADER;
      wr_ind                    <= '0;
      stepready                 <= '0;
      word_tx_data              <= '0;
      clock_divisor             <= `DEFAULT_CLOCK_DIVISOR;
      motor_cfg.enable          <= 1'b0;
      motor_cfg.microsteps      <= `DEFAULT_MICROSTEPS;
      motor_cfg.current         <= `DEFAULT_CURRENT;
      motor_cfg.invert_highside <= `DEFAULT_BRIDGE_INVERTING;
      motor_cfg.invert_lowside  <= `DEFAULT_BRIDGE_INVERTING;
      motor_cfg.spare           <= '0;
    end else if (word_rx) begin
      // Reply is zero unless this word prepares one
      word_tx_data <= '0;
      case (state)
        MSG_HEADER: begin
          case (opcode)
            CMD_COORDINATED_STEP: begin
              state <= MSG_DURATION;
            end
            CMD_MOTOR_ENABLE: begin
              motor_cfg.enable <= word_rx_data[0];
            end
            CMD_CLK_DIVISOR: begin
              clock_divisor <= word_rx_data[7:0];
            end
            CMD_MOTORCONFIG: begin
              motor_cfg.current    <= word_rx_data[15:8];
              motor_cfg.microsteps <= word_rx_data[2:0];
            end
            CMD_BRIDGEINVERT: begin
              motor_cfg.invert_highside <= word_rx_data[1];
              motor_cfg.invert_lowside  <= word_rx_data[0];
            end
            CMD_API_VERSION: begin
              // Goes out during the following word
              word_tx_data <= {40'b0, `VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH};
              state        <= MSG_VERSION_READ;
            end
            // Unknown opcodes are dropped
            default: begin
            end
          endcase
        end
        MSG_DURATION: begin
          state <= MSG_INCREMENT;
        end
        MSG_INCREMENT: begin
          // Host reads it back while sending incinc
          word_tx_data <= encoder_store;
          state        <= MSG_INCINC;
        end
        MSG_INCINC: begin
          // Hand the slot to the timer
          stepready[wr_ind] <= ~stepready[wr_ind];
          wr_ind            <= (wr_ind == LAST_IND) ? '0 : wr_ind + 1'b1;
          state             <= MSG_HEADER;
        end
        MSG_VERSION_READ: begin
          // Filler word of the version read
          state <= MSG_HEADER;
        end
        default: begin
          state <= MSG_HEADER;
        end
      endcase
    end
  end

  // Move parameters and encoder snapshot
  always_ff @(posedge CLK) begin
    if (word_rx) begin
      case (state)
        MSG_HEADER: begin
          if (opcode == CMD_COORDINATED_STEP) begin
            move_buf[wr_ind].dir <= word_rx_data[0];
            encoder_store        <= encoder_count;
          end
        end
        MSG_DURATION: begin
          move_buf[wr_ind].duration <= word_rx_data;
        end
        MSG_INCREMENT: begin
          move_buf[wr_ind].increment <= word_rx_data;
        end
        MSG_INCINC: begin
          move_buf[wr_ind].incinc <= word_rx_data;
        end
        default: begin
        end
      endcase
    end
  end

  // Host flow control keeps moves out of slots still owned by the timer
  a_no_overwrite: assert property (@(posedge CLK) disable iff (!resetn)
    move_word |-> buffer_dtr);

endmodule

//--- hdl/spi_word_link.sv
`timescale 1ns/1ps

module spi_word_link (
  input  logic        CLK,
  input  logic        resetn,
  input  logic        SCK,
  input  logic        CS,
  input  logic        COPI,
  output logic        CIPO,
  input  logic [63:0] word_tx_data,
  output logic        word_rx,
  output logic [63:0] word_rx_data
);

  // Two synchronizer stages plus the previous level in bit 2
  logic [2:0] sck_sync;
  logic [2:0] cs_sync;
  logic [1:0] copi_sync;

  // Registered pin events
  logic sck_rise;
  logic sck_fall;
  logic cs_fall;
  // Data bit aligned with sck_rise
  logic copi_bit;

  logic [6:0]  bit_cnt;
  logic [63:0] rx_shift;
  logic [63:0] tx_shift;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_sync  <= '0;
      cs_sync   <= '1;
      copi_sync <= '0;
      sck_rise  <= 1'b0;
      sck_fall  <= 1'b0;
      cs_fall   <= 1'b0;
    end else begin
      sck_sync  <= {sck_sync[1:0], SCK};
      cs_sync   <= {cs_sync[1:0], CS};
      copi_sync <= {copi_sync[0], COPI};
      // Edge detector stage
      sck_rise  <= sck_sync[1] & ~sck_sync[2];
      sck_fall  <= ~sck_sync[1] & sck_sync[2];
      cs_fall   <= ~cs_sync[1] & cs_sync[2];
    end
  end

  always_ff @(posedge CLK) begin
    copi_bit <= copi_sync[1];
  end

  // Bit counter frames each word and idles while CS is high
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_cnt <= '0;
      word_rx <= 1'b0;
    end else begin
      word_rx <= 1'b0;
      if (cs_sync[1]) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        if (bit_cnt == 7'd63) begin
          bit_cnt <= '0;
          word_rx <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 7'd1;
        end
      end
    end
  end

  // MSB first
  always_ff @(posedge CLK) begin
    if (sck_rise && !cs_sync[1]) begin
      rx_shift <= {rx_shift[62:0], copi_bit};
    end
  end

  // Holds the word until the next rising SCK
  assign word_rx_data = rx_shift;

  // Reply latched at the start of a frame and advanced on falling SCK
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      tx_shift <= '0;
    end else if (cs_fall) begin
      tx_shift <= word_tx_data;
    end else if (sck_fall && !cs_sync[1]) begin
      tx_shift <= {tx_shift[62:0], 1'b0};
    end
  end

  assign CIPO = tx_shift[63];

  // Completed word always belongs to an open CS frame
  a_rx_in_frame: assert property (@(posedge CLK) disable iff (!resetn)
    word_rx |-> !cs_sync[1]);

endmodule

//--- hdl/stepper_defines.svh
`ifndef STEPPER_DEFINES_SVH
`define STEPPER_DEFINES_SVH

// Move buffer

// Number of move slots between the decoder and the DDA timer
`define MOVE_BUFFER_SIZE 2

// Slot index width
`define MOVE_INDEX_BITS $clog2(`MOVE_BUFFER_SIZE)

// API version

// Returned in the low three bytes of the reply word
`define VERSION_MAJOR 8'd0
`define VERSION_MINOR 8'd3
`define VERSION_PATCH 8'd1

// Configuration reset values

// Microstep resolution code
`define DEFAULT_MICROSTEPS 3'd2

// Coil current setting
`define DEFAULT_CURRENT 8'd140

// Step-rate prescaler, CLK cycles per DDA tick
// 40 gives 400 kHz ticks at 16 MHz
`define DEFAULT_CLOCK_DIVISOR 8'd40

// Applies to both high side and low side
`define DEFAULT_BRIDGE_INVERTING 1'b0

`endif

//--- hdl/stepper_pkg.sv
package stepper_pkg;

  // Opcodes in bits 63:56 of a header word
  typedef enum logic [7:0] {
    CMD_COORDINATED_STEP = 8'h01,
    CMD_MOTOR_ENABLE     = 8'h0a,
    CMD_CLK_DIVISOR      = 8'h0f,
    CMD_MOTORCONFIG      = 8'h10,
    CMD_BRIDGEINVERT     = 8'h14,
    CMD_API_VERSION      = 8'hfe
  } cmd_e;

  // Word position inside a message
  typedef enum logic [2:0] {
    MSG_HEADER,
    MSG_DURATION,
    MSG_INCREMENT,
    MSG_INCINC,
    MSG_VERSION_READ
  } msg_state_e;

  // Step timer state
  typedef enum logic {
    DDA_IDLE,
    DDA_RUN
  } dda_state_e;

  // Motor driver configuration, 20 bits
  typedef struct packed {
    logic       enable;
    logic [2:0] microsteps;
    logic [7:0] current;
    logic       invert_highside;
    logic       invert_lowside;
    logic [5:0] spare;
  } motor_config_t;

  // One buffered move, 193 bits
  // Increment in 32.32 fixed point, steps per tick
  typedef struct packed {
    logic        [63:0] duration;
    logic signed [63:0] increment;
    logic signed [63:0] incinc;
    logic               dir;
  } move_params_t;

endpackage

//--- hdl/stepper_spi_top.sv
`timescale 1ns/1ps
`include "stepper_defines.svh"

module stepper_spi_top
  import stepper_pkg::*;
(
  input  logic          CLK,
  input  logic          resetn,
  input  logic          SCK,
  input  logic          CS,
  input  logic          COPI,
  output logic          CIPO,
  input  logic [63:0]   encoder_count,
  output logic          step,
  output logic          dir,
  output logic          enable,
  output logic          buffer_dtr,
  output motor_config_t motor_cfg
);

  // SPI word interface
  logic [63:0] word_tx_data;
  logic [63:0] word_rx_data;
  logic        word_rx;

  // Decoder to timer
  logic [7:0]                   clock_divisor;
  move_params_t                 move_buf [`MOVE_BUFFER_SIZE];
  logic [`MOVE_BUFFER_SIZE-1:0] stepready;
  logic [`MOVE_BUFFER_SIZE-1:0] stepfinished;

  spi_word_link i_spi_word_link (
    .CLK          (CLK),
    .resetn       (resetn),
    .SCK          (SCK),
    .CS           (CS),
    .COPI         (COPI),
    .CIPO         (CIPO),
    .word_tx_data (word_tx_data),
    .word_rx      (word_rx),
    .word_rx_data (word_rx_data)
  );

  move_command_fsm i_move_command_fsm (
    .CLK           (CLK),
    .resetn        (resetn),
    .word_rx       (word_rx),
    .word_rx_data  (word_rx_data),
    .encoder_count (encoder_count),
    .stepfinished  (stepfinished),
    .word_tx_data  (word_tx_data),
    .motor_cfg     (motor_cfg),
    .clock_divisor (clock_divisor),
    .move_buf      (move_buf),
    .stepready     (stepready),
    .buffer_dtr    (buffer_dtr)
  );

  dda_step_timer i_dda_step_timer (
    .CLK           (CLK),
    .resetn        (resetn),
    .clock_divisor (clock_divisor),
    .move_buf      (move_buf),
    .stepready     (stepready),
    .stepfinished  (stepfinished),
    .step          (step),
    .dir           (dir)
  );

  // Driver enable pin
  assign enable = motor_cfg.enable;

endmodule

//--- stepper_spi_top.f
+incdir+hdl
hdl/stepper_pkg.sv
hdl/spi_word_link.sv
hdl/move_command_fsm.sv
hdl/dda_step_timer.sv
hdl/stepper_spi_top.sv
tests/tb_clock_gen.sv
tests/stepper_spi_tb.sv

//--- tests/stepper_spi_tb.sv
`timescale 1ns/1ps
`include "stepper_defines.svh"

module stepper_spi_tb
  import stepper_pkg::*;
();

  localparam int DRIVE_DELAY = 10;
  localparam logic [31:0] SEED = 32'h22c094c4;
  // Words per test: config 3, version 2, encoder 4, steps 8, flow 8
  localparam int TOTAL_WORDS = 25;
  localparam int WORD_BUDGET = 600;
  localparam int LONG_DUR = 150;
  localparam int TICK_DIV = int'(`DEFAULT_CLOCK_DIVISOR);
  localparam int TIMEOUT_CYCLES = 2 * (TOTAL_WORDS * WORD_BUDGET + LONG_DUR * TICK_DIV);

  logic          CLK;
  logic          resetn;
  logic          SCK;
  logic          CS;
  logic          COPI;
  logic          CIPO;
  logic [63:0]   encoder_count;
  logic          step;
  logic          dir;
  logic          enable;
  logic          buffer_dtr;
  motor_config_t motor_cfg;

  logic [31:0] lcg_state;
  logic [63:0] move_reply [4];
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int error_mark = 0;
  int cycle_count = 0;
  // Step pulses split by dir level
  int steps_fwd = 0;
  int steps_rev = 0;

  tb_clock_gen #(.PERIOD_NS(100.0)) i_tb_clock_gen (.CLK(CLK));

  stepper_spi_top i_stepper_spi_top (
    .CLK           (CLK),
    .resetn        (resetn),
    .SCK           (SCK),
    .CS            (CS),
    .COPI          (COPI),
    .CIPO          (CIPO),
    .encoder_count (encoder_count),
    .step          (step),
    .dir           (dir),
    .enable        (enable),
    .buffer_dtr    (buffer_dtr),
    .motor_cfg     (motor_cfg)
  );

  // Step counter
  always @(posedge CLK) begin
    if (resetn && step) begin
      if (dir) begin
        steps_fwd <= steps_fwd + 1;
      end else begin
        steps_rev <= steps_rev + 1;
      end
    end
  end

  // Run limit
  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // DDA rule: add increment, then incinc; step on integer change
  function automatic int expected_steps(input move_params_t mv);
    logic signed [63:0] acc;
    logic signed [63:0] inc;
    logic signed [63:0] nxt;
    logic [63:0] t;
    int n;
    n = 0;
    acc = '0;
    inc = mv.increment;
    for (t = 64'd0; t < mv.duration; t = t + 64'd1) begin
      nxt = acc + inc;
      if (nxt[63:32] != acc[63:32]) begin
        n = n + 1;
      end
      acc = nxt;
      inc = inc + mv.incinc;
    end
    return n;
  endfunction

  // Back to the drive point after n rising edges
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge CLK);
    #DRIVE_DELAY;
  endtask

  task automatic check_word(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_cfg(input string name, input motor_config_t got, input motor_config_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input string name);
    tests++;
    if (errors == error_mark) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - error_mark);
    end
    error_mark = errors;
  endtask

  // Mode 0 host, 8 CLK cycles per SCK period, CIPO read late in the high phase
  task automatic spi_xfer(input logic [63:0] tx, output logic [63:0] rx);
    logic [63:0] shift_in;
    int i;
    shift_in = '0;
    CS = 1'b0;
    for (i = 63; i >= 0; i--) begin
      COPI = tx[i];
      wait_cycles(4);
      SCK = 1'b1;
      wait_cycles(4);
      shift_in = {shift_in[62:0], CIPO};
      SCK = 1'b0;
    end
    wait_cycles(4);
    CS = 1'b1;
    COPI = 1'b0;
    // Gap between frames
    wait_cycles(8);
    rx = shift_in;
  endtask

  // Host flow control before the header
  task automatic send_move(input move_params_t mv);
    while (!buffer_dtr) wait_cycles(1);
    spi_xfer({CMD_COORDINATED_STEP, 55'd0, mv.dir}, move_reply[0]);
    spi_xfer(mv.duration, move_reply[1]);
    spi_xfer(mv.increment, move_reply[2]);
    spi_xfer(mv.incinc, move_reply[3]);
  endtask

  // All slots played, last pulse counted
  task automatic wait_idle();
    while (i_stepper_spi_top.stepready != i_stepper_spi_top.stepfinished) wait_cycles(1);
    wait_cycles(2);
  endtask

  task automatic verify_defaults();
    motor_config_t exp;
    exp = '0;
    exp.microsteps      = `DEFAULT_MICROSTEPS;
    exp.current         = `DEFAULT_CURRENT;
    exp.invert_highside = `DEFAULT_BRIDGE_INVERTING;
    exp.invert_lowside  = `DEFAULT_BRIDGE_INVERTING;
    check_cfg("motor_cfg", motor_cfg, exp);
    check_bit("enable", enable, 1'b0);
    check_bit("step", step, 1'b0);
    check_bit("CIPO", CIPO, 1'b0);
    check_bit("buffer_dtr", buffer_dtr, 1'b1);
    report_test("verify_defaults");
  endtask

  task automatic write_config();
    motor_config_t exp;
    logic [63:0] rx;
    spi_xfer({CMD_MOTORCONFIG, 40'd0, 8'h5a, 5'd0, 3'd5}, rx);
    spi_xfer({CMD_MOTOR_ENABLE, 55'd0, 1'b1}, rx);
    spi_xfer({CMD_BRIDGEINVERT, 54'd0, 2'b10}, rx);
    exp = '0;
    exp.enable          = 1'b1;
    exp.microsteps      = 3'd5;
    exp.current         = 8'h5a;
    exp.invert_highside = 1'b1;
    exp.invert_lowside  = 1'b0;
    check_cfg("motor_cfg", motor_cfg, exp);
    check_bit("enable", enable, 1'b1);
    report_test("write_config");
  endtask

  task automatic read_api_version();
    logic [63:0] rx;
    spi_xfer({CMD_API_VERSION, 56'd0}, rx);
    check_word("reply on header", rx, 64'd0);
    spi_xfer(64'd0, rx);
    check_word("version reply", rx,
               {40'd0, `VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH});
    report_test("read_api_version");
  endtask

  task automatic move_encoder_reply();
    move_params_t mv;
    logic [63:0] enc;
    enc = {next_random(), next_random()};
    encoder_count = enc;
    mv.duration  = 64'd3;
    mv.increment = '0;
    mv.incinc    = '0;
    mv.dir       = 1'b0;
    send_move(mv);
    check_word("reply on header", move_reply[0], 64'd0);
    check_word("reply on duration", move_reply[1], 64'd0);
    check_word("reply on increment", move_reply[2], 64'd0);
    check_word("reply on incinc", move_reply[3], enc);
    wait_idle();
    report_test("move_encoder_reply");
  endtask

  task automatic dda_step_counts();
    move_params_t cruise;
    move_params_t ramp;
    logic [31:0] r;
    int fwd_base;
    int rev_base;
    // Constant rate, forward
    cruise.duration  = 64'd40 + 64'(next_random() % 32'd24);
    cruise.increment = {32'd0, next_random()};
    cruise.incinc    = '0;
    cruise.dir       = 1'b1;
    // Accelerating, reverse
    ramp.duration  = 64'd40 + 64'(next_random() % 32'd24);
    r = next_random();
    ramp.increment = {34'd0, r[31:2]};
    r = next_random();
    ramp.incinc    = {40'd0, r[31:8]};
    ramp.dir       = 1'b0;
    fwd_base = steps_fwd;
    rev_base = steps_rev;
    send_move(cruise);
    send_move(ramp);
    wait_idle();
    check_count("forward steps", steps_fwd - fwd_base, expected_steps(cruise));
    check_count("reverse steps", steps_rev - rev_base, expected_steps(ramp));
    check_bit("dir", dir, 1'b0);
    report_test("dda_step_counts");
  endtask

  task automatic buffer_back_pressure();
    move_params_t first;
    move_params_t second;
    int fwd_base;
    int rev_base;
    first.duration  = 64'(LONG_DUR);
    first.increment = 64'h0000_0000_4000_0000;
    first.incinc    = '0;
    first.dir       = 1'b1;
    second     = first;
    second.dir = 1'b0;
    fwd_base = steps_fwd;
    rev_base = steps_rev;
    send_move(first);
    send_move(second);
    check_bit("buffer_dtr with both slots pending", buffer_dtr, 1'b0);
    while (!buffer_dtr) wait_cycles(1);
    wait_cycles(2);
    check_count("steps at first move end", steps_fwd - fwd_base, expected_steps(first));
    check_count("second move steps so far", steps_rev - rev_base, 0);
    wait_idle();
    check_count("second move steps", steps_rev - rev_base, expected_steps(second));
    check_bit("buffer_dtr when idle", buffer_dtr, 1'b1);
    report_test("buffer_back_pressure");
  endtask

  initial begin
    resetn = 1'b0;
    SCK = 1'b0;
    CS = 1'b1;
    COPI = 1'b0;
    encoder_count = '0;
    lcg_state = SEED;
    wait_cycles(10);
    resetn = 1'b1;
    wait_cycles(2);
    verify_defaults();
    write_config();
    read_api_version();
    move_encoder_reply();
    dda_step_counts();
    buffer_back_pressure();
    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real PERIOD_NS = 100.0
) (
  output logic CLK
);

  // Free running, starts low
  initial begin
    CLK = 1'b0;
    forever #(PERIOD_NS / 2.0) CLK = ~CLK;
  end

endmodule
